//--- alu_pipe.f
+incdir+design
design/alu_pkg.sv
design/alu_shift_unit.sv
design/alu_decode_stage.sv
design/alu_execute_stage.sv
design/alu_pipe.sv
sim/alu_pipe_checker.sv
sim/alu_pipe_tb.sv

//--- design/alu_decode_stage.sv
`include "alu_settings.svh"

module alu_decode_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  alu_pkg::alu_instr_u    instruction,
    input  logic [`ALU_DATA_W-1:0] reg_a,
    input  logic [`ALU_DATA_W-1:0] reg_b,
    output alu_pkg::alu_stage_s    stage
);

    alu_pkg::alu_op_e       op;
    logic                   ovf_en;
    logic                   use_imm;
    logic                   sign_imm;
    logic [`ALU_DATA_W-1:0] zext_imm;
    logic [`ALU_DATA_W-1:0] sext_imm;
    logic [`ALU_DATA_W-1:0] operand_b;
    alu_pkg::alu_stage_s    stage_next;

    assign zext_imm = {{(`ALU_DATA_W-`ALU_IMM_W){1'b0}}, instruction.i.imm};
    assign sext_imm = {{(`ALU_DATA_W-`ALU_IMM_W){instruction.i.imm[`ALU_IMM_W-1]}},
                       instruction.i.imm};

    always_comb begin
        op       = alu_pkg::ALU_OP_NONE;
        ovf_en   = 1'b0;
        use_imm  = 1'b0;
        sign_imm = 1'b0;
        case (instruction.r.opcode)
            `ALU_OPC_RTYPE: begin
                case (instruction.r.func)
                    `ALU_FN_ADD: begin
                        op     = alu_pkg::ALU_OP_ADD;
                        ovf_en = 1'b1;
                    end
                    `ALU_FN_ADDU: op = alu_pkg::ALU_OP_ADD;
                    `ALU_FN_SUB: begin
                        op     = alu_pkg::ALU_OP_SUB;
                        ovf_en = 1'b1;
                    end
                    `ALU_FN_SUBU: op = alu_pkg::ALU_OP_SUB;
                    `ALU_FN_AND:  op = alu_pkg::ALU_OP_AND;
                    `ALU_FN_OR:   op = alu_pkg::ALU_OP_OR;
                    `ALU_FN_XOR:  op = alu_pkg::ALU_OP_XOR;
                    `ALU_FN_NOR:  op = alu_pkg::ALU_OP_NOR;
                    `ALU_FN_SLT:  op = alu_pkg::ALU_OP_SLT;
                    `ALU_FN_SLTU: op = alu_pkg::ALU_OP_SLTU;
                    `ALU_FN_SLL:  op = alu_pkg::ALU_OP_SLL;
                    `ALU_FN_SRL:  op = alu_pkg::ALU_OP_SRL;
                    `ALU_FN_SRA:  op = alu_pkg::ALU_OP_SRA;
                    `ALU_FN_SLLV: op = alu_pkg::ALU_OP_SLLV;
                    `ALU_FN_SRLV: op = alu_pkg::ALU_OP_SRLV;
                    `ALU_FN_SRAV: op = alu_pkg::ALU_OP_SRAV;
                    default:      op = alu_pkg::ALU_OP_NONE;
                endcase
            end
            `ALU_OPC_ADDI: begin
                op       = alu_pkg::ALU_OP_ADD;
                ovf_en   = 1'b1;
                use_imm  = 1'b1;
                sign_imm = 1'b1;
            end
            `ALU_OPC_ADDIU: begin
                op       = alu_pkg::ALU_OP_ADD;
                use_imm  = 1'b1;
                sign_imm = 1'b1;
            end
            `ALU_OPC_SLTI: begin
                op       = alu_pkg::ALU_OP_SLT;
                use_imm  = 1'b1;
                sign_imm = 1'b1;
            end
            // unsigned compare, yet the immediate is still sign-extended
            `ALU_OPC_SLTIU: begin
                op       = alu_pkg::ALU_OP_SLTU;
                use_imm  = 1'b1;
                sign_imm = 1'b1;
            end
            `ALU_OPC_ANDI: begin
                op      = alu_pkg::ALU_OP_AND;
                use_imm = 1'b1;
            end
            `ALU_OPC_ORI: begin
                op      = alu_pkg::ALU_OP_OR;
                use_imm = 1'b1;
            end
            `ALU_OPC_XORI: begin
                op      = alu_pkg::ALU_OP_XOR;
                use_imm = 1'b1;
            end
            default: op = alu_pkg::ALU_OP_NONE;
        endcase
    end

    assign operand_b = !use_imm ? reg_b : (sign_imm ? sext_imm : zext_imm);

    always_comb begin
        stage_next.op     = op;
        stage_next.ovf_en = ovf_en;
        stage_next.a      = reg_a;
        stage_next.b      = operand_b;
        stage_next.shamt  = instruction.r.shamt;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage <= '0;
        end else begin
            stage <= stage_next;
        end
    end

    // an X on the word would silently decode as an unknown op
    a_instr_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(instruction)
    ) else $error("instruction has unknown bits");

endmodule

//--- design/alu_execute_stage.sv
`include "alu_settings.svh"

module alu_execute_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  alu_pkg::alu_stage_s stage,
    output alu_pkg::alu_out_s   out
);

    logic [`ALU_DATA_W-1:0] sum;
    logic [`ALU_DATA_W-1:0] diff;
    logic [`ALU_DATA_W-1:0] shifted;
    logic                   add_ovf;
    logic                   sub_ovf;
    logic                   lt_signed;
    logic                   lt_unsigned;
    alu_pkg::alu_out_s      out_next;

    localparam int MSB = `ALU_DATA_W - 1;

    assign sum  = stage.a + stage.b;
    assign diff = stage.a - stage.b;

    // same-sign operands giving a result of the other sign
    assign add_ovf = (stage.a[MSB] == stage.b[MSB]) && (sum[MSB] != stage.a[MSB]);
    // for a - b the operands must differ in sign
    assign sub_ovf = (stage.a[MSB] != stage.b[MSB]) && (diff[MSB] != stage.a[MSB]);

    assign lt_signed   = $signed(stage.a) < $signed(stage.b);
    assign lt_unsigned = stage.a < stage.b;

    alu_shift_unit shift_i (
        .op      (stage.op),
        .a       (stage.a),
        .b       (stage.b),
        .shamt   (stage.shamt),
        .shifted (shifted)
    );

    always_comb begin
        out_next = '0;
        case (stage.op)
            alu_pkg::ALU_OP_ADD: begin
                out_next.result         = sum;
                out_next.flags.overflow = stage.ovf_en && add_ovf;
            end
            alu_pkg::ALU_OP_SUB: begin
                out_next.result         = diff;
                out_next.flags.overflow = stage.ovf_en && sub_ovf;
            end
            alu_pkg::ALU_OP_AND: begin
                out_next.result = stage.a & stage.b;
            end
            alu_pkg::ALU_OP_OR: begin
                out_next.result = stage.a | stage.b;
            end
            alu_pkg::ALU_OP_XOR: begin
                out_next.result = stage.a ^ stage.b;
            end
            alu_pkg::ALU_OP_NOR: begin
                out_next.result = ~(stage.a | stage.b);
            end
            // compares return the difference, the outcome rides on negative
            alu_pkg::ALU_OP_SLT: begin
                out_next.result         = diff;
                out_next.flags.negative = lt_signed;
            end
            alu_pkg::ALU_OP_SLTU: begin
                out_next.result         = diff;
                out_next.flags.negative = lt_unsigned;
            end
            alu_pkg::ALU_OP_SLL,
            alu_pkg::ALU_OP_SRL,
            alu_pkg::ALU_OP_SRA,
            alu_pkg::ALU_OP_SLLV,
            alu_pkg::ALU_OP_SRLV,
            alu_pkg::ALU_OP_SRAV: begin
                out_next.result = shifted;
            end
            default: begin
                out_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out <= '0;
        end else begin
            out <= out_next;
        end
    end

    // overflow can only come from a trapping add or sub one cycle back
    a_ovf_source: assert property (
        @(posedge clk) disable iff (!arst_n)
        out.flags.overflow |->
            $past(stage.ovf_en) &&
            (($past(stage.op) == alu_pkg::ALU_OP_ADD) ||
             ($past(stage.op) == alu_pkg::ALU_OP_SUB))
    ) else $error("overflow set without an enabled add or sub");

    a_neg_source: assert property (
        @(posedge clk) disable iff (!arst_n)
        out.flags.negative |->
            ($past(stage.op) == alu_pkg::ALU_OP_SLT) ||
            ($past(stage.op) == alu_pkg::ALU_OP_SLTU)
    ) else $error("negative set outside a compare");

endmodule

//--- design/alu_pipe.sv
`include "alu_settings.svh"

module alu_pipe (
    input  logic                   clk,
    input  logic                   arst_n,
    input  alu_pkg::alu_instr_u    instruction,
    input  logic [`ALU_DATA_W-1:0] reg_a,
    input  logic [`ALU_DATA_W-1:0] reg_b,
    output logic [`ALU_DATA_W-1:0] result,
    output alu_pkg::alu_flags_s    flags
);

    alu_pkg::alu_stage_s stage;
    alu_pkg::alu_out_s   out_q;

    // decode, one cycle
    alu_decode_stage decode_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instruction (instruction),
        .reg_a       (reg_a),
        .reg_b       (reg_b),
        .stage       (stage)
    );

    // execute, one cycle
    alu_execute_stage execute_i (
        .clk    (clk),
        .arst_n (arst_n),
        .stage  (stage),
        .out    (out_q)
    );

    assign result = out_q.result;
    assign flags  = out_q.flags;

endmodule

//--- design/alu_pkg.sv
`include "alu_settings.svh"

package alu_pkg;

    // R-type view of the instruction word
    typedef struct packed {
        logic [5:0]              opcode;
        logic [4:0]              rs;
        logic [4:0]              rt;
        logic [4:0]              rd;
        logic [`ALU_SHAMT_W-1:0] shamt;
        logic [5:0]              func;
    } alu_rtype_s;

    // I-type view of the same word
    typedef struct packed {
        logic [5:0]            opcode;
        logic [4:0]            rs;
        logic [4:0]            rt;
        logic [`ALU_IMM_W-1:0] imm;
    } alu_itype_s;

    typedef union packed {
        alu_rtype_s r;
        alu_itype_s i;
    } alu_instr_u;

    // add and addu share one class, the overflow enable tells them apart
    typedef enum logic [4:0] {
        ALU_OP_NONE = 5'd0,
        ALU_OP_ADD  = 5'd1,
        ALU_OP_SUB  = 5'd2,
        ALU_OP_AND  = 5'd3,
        ALU_OP_OR   = 5'd4,
        ALU_OP_XOR  = 5'd5,
        ALU_OP_NOR  = 5'd6,
        ALU_OP_SLT  = 5'd7,
        ALU_OP_SLTU = 5'd8,
        ALU_OP_SLL  = 5'd9,
        ALU_OP_SRL  = 5'd10,
        ALU_OP_SRA  = 5'd11,
        ALU_OP_SLLV = 5'd12,
        ALU_OP_SRLV = 5'd13,
        ALU_OP_SRAV = 5'd14
    } alu_op_e;

    // decode to execute bundle
    typedef struct packed {
        alu_op_e                 op;
        logic                    ovf_en;
        logic [`ALU_DATA_W-1:0]  a;
        logic [`ALU_DATA_W-1:0]  b;
        logic [`ALU_SHAMT_W-1:0] shamt;
    } alu_stage_s;

    typedef struct packed {
        logic negative;
        logic overflow;
    } alu_flags_s;

    typedef struct packed {
        logic [`ALU_DATA_W-1:0] result;
        alu_flags_s             flags;
    } alu_out_s;

endpackage

//--- design/alu_settings.svh
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

`define ALU_DATA_W  32
`define ALU_IMM_W   16
`define ALU_SHAMT_W 5

// opcode field values
`define ALU_OPC_RTYPE 6'h00
`define ALU_OPC_ADDI  6'h08
`define ALU_OPC_ADDIU 6'h09
`define ALU_OPC_SLTI  6'h0a
`define ALU_OPC_SLTIU 6'h0b
`define ALU_OPC_ANDI  6'h0c
`define ALU_OPC_ORI   6'h0d
`define ALU_OPC_XORI  6'h0e

// function field values, R-type only
`define ALU_FN_SLL  6'h00
`define ALU_FN_SRL  6'h02
`define ALU_FN_SRA  6'h03
`define ALU_FN_SLLV 6'h04
`define ALU_FN_SRLV 6'h06
`define ALU_FN_SRAV 6'h07
`define ALU_FN_ADD  6'h20
`define ALU_FN_ADDU 6'h21
`define ALU_FN_SUB  6'h22
`define ALU_FN_SUBU 6'h23
`define ALU_FN_AND  6'h24
`define ALU_FN_OR   6'h25
`define ALU_FN_XOR  6'h26
`define ALU_FN_NOR  6'h27
`define ALU_FN_SLT  6'h2a
`define ALU_FN_SLTU 6'h2b

`endif

//--- design/alu_shift_unit.sv
`include "alu_settings.svh"

module alu_shift_unit (
    input  alu_pkg::alu_op_e        op,
    input  logic [`ALU_DATA_W-1:0]  a,
    input  logic [`ALU_DATA_W-1:0]  b,
    input  logic [`ALU_SHAMT_W-1:0] shamt,
    output logic [`ALU_DATA_W-1:0]  shifted
);

    logic                    variable;
    logic                    out_of_range;
    logic [`ALU_SHAMT_W-1:0] amount;
    logic [`ALU_DATA_W-1:0]  left;
    logic [`ALU_DATA_W-1:0]  right_log;
    logic [`ALU_DATA_W-1:0]  right_arith;

    assign variable = (op == alu_pkg::ALU_OP_SLLV) ||
                      (op == alu_pkg::ALU_OP_SRLV) ||
                      (op == alu_pkg::ALU_OP_SRAV);

    // variable forms take the whole of b, so any upper bit means 32 or more
    assign out_of_range = variable && (|b[`ALU_DATA_W-1:`ALU_SHAMT_W]);
    assign amount       = variable ? b[`ALU_SHAMT_W-1:0] : shamt;

    assign left        = a << amount;
    assign right_log   = a >> amount;
    assign right_arith = $signed(a) >>> amount;

    always_comb begin
        case (op)
            alu_pkg::ALU_OP_SLL,
            alu_pkg::ALU_OP_SLLV: begin
                shifted = out_of_range ? '0 : left;
            end
            alu_pkg::ALU_OP_SRL,
            alu_pkg::ALU_OP_SRLV: begin
                shifted = out_of_range ? '0 : right_log;
            end
            alu_pkg::ALU_OP_SRA,
            alu_pkg::ALU_OP_SRAV: begin
                // sign fill once everything has shifted out
                shifted = out_of_range ? {`ALU_DATA_W{a[`ALU_DATA_W-1]}} : right_arith;
            end
            default: begin
                shifted = '0;
            end
        endcase
    end

endmodule

//--- sim/alu_pipe_checker.sv
`include "alu_settings.svh"

module alu_pipe_checker (
    input  logic                   clk,
    input  logic                   arst_n,
    input  alu_pkg::alu_instr_u    instruction,
    input  logic [`ALU_DATA_W-1:0] reg_a,
    input  logic [`ALU_DATA_W-1:0] reg_b,
    input  logic [`ALU_DATA_W-1:0] result,
    input  alu_pkg::alu_flags_s    flags,
    input  int                     test_num,
    input  logic                   run_done,
    output int                     errors
);

    timeunit 1ns;
    timeprecision 1ps;

    alu_pkg::alu_out_s exp_now = '0;
    alu_pkg::alu_out_s exp_late = '0;
    int                tag_now = 1;
    int                tag_late = 1;
    int                last_tag = 1;
    int                checks = 0;
    int                test_errors = 0;
    int                mismatches = 0;
    int                tests_ok = 0;
    int                tests_bad = 0;

    assign errors = mismatches;

    // true when a signed value has no 32-bit signed form
    function automatic bit overflows(longint value);
        return value != longint'(int'(value));
    endfunction

    function automatic alu_pkg::alu_out_s expected_out(alu_pkg::alu_instr_u ins,
                                                       logic [31:0] a, logic [31:0] b);
        logic [31:0] simm;
        logic [31:0] zimm;
        longint      sa;
        longint      sb;
        longint      si;
        simm = {{16{ins.i.imm[15]}}, ins.i.imm};
        zimm = {16'h0000, ins.i.imm};
        sa   = $signed(a);
        sb   = $signed(b);
        si   = $signed(simm);
        case (ins.i.opcode)
            `ALU_OPC_RTYPE: begin
                case (ins.r.func)
                    `ALU_FN_ADD:  return '{a + b, '{1'b0, overflows(sa + sb)}};
                    `ALU_FN_ADDU: return '{a + b, '0};
                    `ALU_FN_SUB:  return '{a - b, '{1'b0, overflows(sa - sb)}};
                    `ALU_FN_SUBU: return '{a - b, '0};
                    `ALU_FN_AND:  return '{a & b, '0};
                    `ALU_FN_OR:   return '{a | b, '0};
                    `ALU_FN_XOR:  return '{a ^ b, '0};
                    `ALU_FN_NOR:  return '{~(a | b), '0};
                    `ALU_FN_SLT:  return '{a - b, '{sa < sb, 1'b0}};
                    `ALU_FN_SLTU: return '{a - b, '{a < b, 1'b0}};
                    `ALU_FN_SLL:  return '{a << ins.r.shamt, '0};
                    `ALU_FN_SRL:  return '{a >> ins.r.shamt, '0};
                    `ALU_FN_SRA:  return '{$signed(a) >>> ins.r.shamt, '0};
                    // variable forms shift by all of regB
                    `ALU_FN_SLLV: return '{a << b, '0};
                    `ALU_FN_SRLV: return '{a >> b, '0};
                    `ALU_FN_SRAV: return '{$signed(a) >>> b, '0};
                    default:      return '0;
                endcase
            end
            `ALU_OPC_ADDI:  return '{a + simm, '{1'b0, overflows(sa + si)}};
            `ALU_OPC_ADDIU: return '{a + simm, '0};
            `ALU_OPC_SLTI:  return '{a - simm, '{sa < si, 1'b0}};
            `ALU_OPC_SLTIU: return '{a - simm, '{a < simm, 1'b0}};
            `ALU_OPC_ANDI:  return '{a & zimm, '0};
            `ALU_OPC_ORI:   return '{a | zimm, '0};
            `ALU_OPC_XORI:  return '{a ^ zimm, '0};
            default:        return '0;
        endcase
    endfunction

    task automatic close_test(int num);
        if (test_errors == 0) begin
            $display("test %0d finished, %0d outputs matched", num, checks);
            tests_ok++;
        end else begin
            $display("test %0d finished with %0d mismatches in %0d outputs",
                     num, test_errors, checks);
            tests_bad++;
        end
        checks      = 0;
        test_errors = 0;
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            exp_now  <= '0;
            exp_late <= '0;
        end else begin
            exp_now  <= expected_out(instruction, reg_a, reg_b);
            exp_late <= exp_now;
        end
        tag_now  <= test_num;
        tag_late <= tag_now;
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (tag_late != last_tag) begin
            close_test(last_tag);
            last_tag = tag_late;
        end
        checks++;
        if (result !== exp_late.result) begin
            $display("[ERROR] %0t result expected %h actual %h", $time, exp_late.result, result);
            test_errors++;
            mismatches++;
        end
        if (flags.negative !== exp_late.flags.negative) begin
            $display("[ERROR] %0t flags.negative expected %b actual %b",
                     $time, exp_late.flags.negative, flags.negative);
            test_errors++;
            mismatches++;
        end
        if (flags.overflow !== exp_late.flags.overflow) begin
            $display("[ERROR] %0t flags.overflow expected %b actual %b",
                     $time, exp_late.flags.overflow, flags.overflow);
            test_errors++;
            mismatches++;
        end
    end

    initial begin
        @(posedge run_done);
        $display("%0d tests clean, %0d tests with mismatches, %0d mismatches in total",
                 tests_ok, tests_bad, mismatches);
    end

endmodule

//--- sim/alu_pipe_tb.sv
`include "alu_settings.svh"

module alu_pipe_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TESTS      = 6;
    localparam int N_ITEMS      = 200;
    localparam int RST_CYCLES   = 2;
    localparam int IDLE_CYCLES  = 2;
    localparam int DRAIN_CYCLES = 4;
    localparam int CYCLE_LIMIT  =
        (N_TESTS * N_ITEMS + RST_CYCLES + IDLE_CYCLES + DRAIN_CYCLES) * 11 / 10;

    logic                   clk;
    logic                   arst_n;
    alu_pkg::alu_instr_u    instruction;
    logic [`ALU_DATA_W-1:0] reg_a;
    logic [`ALU_DATA_W-1:0] reg_b;
    logic [`ALU_DATA_W-1:0] result;
    alu_pkg::alu_flags_s    flags;
    int                     test_num;
    logic                   run_done;
    int                     errors;
    int                     cycle_count;

    logic [31:0] corners [5] = '{32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h1};

    // {r-type, func or opcode} for each kept instruction
    logic [6:0] kept_codes [23] = '{
        {1'b1, `ALU_FN_ADD}, {1'b1, `ALU_FN_ADDU}, {1'b1, `ALU_FN_SUB}, {1'b1, `ALU_FN_SUBU},
        {1'b0, `ALU_OPC_ADDI}, {1'b0, `ALU_OPC_ADDIU},
        {1'b1, `ALU_FN_AND}, {1'b1, `ALU_FN_OR}, {1'b1, `ALU_FN_XOR}, {1'b1, `ALU_FN_NOR},
        {1'b0, `ALU_OPC_ANDI}, {1'b0, `ALU_OPC_ORI}, {1'b0, `ALU_OPC_XORI},
        {1'b1, `ALU_FN_SLT}, {1'b1, `ALU_FN_SLTU}, {1'b0, `ALU_OPC_SLTI}, {1'b0, `ALU_OPC_SLTIU},
        {1'b1, `ALU_FN_SLL}, {1'b1, `ALU_FN_SRL}, {1'b1, `ALU_FN_SRA},
        {1'b1, `ALU_FN_SLLV}, {1'b1, `ALU_FN_SRLV}, {1'b1, `ALU_FN_SRAV}
    };

    alu_pipe alu_pipe_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instruction (instruction),
        .reg_a       (reg_a),
        .reg_b       (reg_b),
        .result      (result),
        .flags       (flags)
    );

    alu_pipe_checker checker_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instruction (instruction),
        .reg_a       (reg_a),
        .reg_b       (reg_b),
        .result      (result),
        .flags       (flags),
        .test_num    (test_num),
        .run_done    (run_done),
        .errors      (errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // register fields the ALU ignores stay random
    function automatic alu_pkg::alu_instr_u make_instr(int k, logic [4:0] shamt,
                                                       logic [15:0] imm);
        alu_pkg::alu_instr_u ins;
        ins = $urandom;
        if (kept_codes[k][6]) begin
            ins.r.opcode = `ALU_OPC_RTYPE;
            ins.r.shamt  = shamt;
            ins.r.func   = kept_codes[k][5:0];
        end else begin
            ins.i.opcode = kept_codes[k][5:0];
            ins.i.imm    = imm;
        end
        return ins;
    endfunction

    // the test number travels with the item it belongs to
    task automatic drive(alu_pkg::alu_instr_u ins, logic [31:0] a, logic [31:0] b, int tag);
        @(negedge clk);
        instruction = ins;
        reg_a       = a;
        reg_b       = b;
        test_num    = tag;
    endtask

    task automatic run_item(int t, int n);
        logic [31:0]         a;
        logic [31:0]         b;
        logic [15:0]         imm;
        int                  k;
        alu_pkg::alu_instr_u ins;
        a   = $urandom;
        b   = $urandom;
        imm = $urandom;
        ins = $urandom;
        case (t)
            1: begin
                if (n % 3 == 0) begin
                    a   = corners[$urandom_range(0, 4)];
                    b   = corners[$urandom_range(0, 4)];
                    imm = (n % 2) ? 16'h8000 : 16'h7fff;
                end
                ins = make_instr($urandom_range(0, 5), 5'd0, imm);
            end
            2: ins = make_instr($urandom_range(6, 12), 5'd0, imm | 16'h8000);
            3: begin
                b[31]   = ~a[31];
                imm[15] = ~a[31];
                ins     = make_instr($urandom_range(13, 16), 5'd0, imm);
            end
            4: begin
                if (n < 96) begin
                    k = 17 + n / 32;
                end else begin
                    k = 20 + n % 3;
                    b = (n % 4 < 2) ? $urandom_range(0, 31) :
                        ((n % 4 == 2) ? $urandom_range(32, 63) : $urandom);
                end
                if (k == 19 || k == 22) a[31] = 1'b1;
                ins = make_instr(k, 5'(n % 32), imm);
            end
            5: begin
                case (n % 6)
                    0: ins.i.opcode = 6'h04;
                    1: ins.i.opcode = 6'h05;
                    2: ins.i.opcode = 6'h23;
                    3: ins.i.opcode = 6'h2b;
                    4: ins.i.opcode = 6'h10 + 6'($urandom_range(0, 47));
                    default: begin
                        ins.r.opcode = `ALU_OPC_RTYPE;
                        ins.r.func   = 6'h08 + 6'($urandom_range(0, 23));
                    end
                endcase
            end
            default: ins = make_instr($urandom_range(0, 22), 5'($urandom), imm);
        endcase
        drive(ins, a, b, t);
    endtask

    initial begin
        void'($urandom(32'h236a_52f5));
        arst_n      = 1'b0;
        instruction = '0;
        reg_a       = '0;
        reg_b       = '0;
        test_num    = 1;
        run_done    = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        repeat (IDLE_CYCLES) drive('0, '0, '0, 1);
        for (int t = 1; t <= N_TESTS; t++) begin
            for (int n = 0; n < N_ITEMS; n++) begin
                run_item(t, n);
            end
        end
        repeat (DRAIN_CYCLES) drive('0, '0, '0, 0);
        run_done = 1'b1;
        @(posedge clk);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped: tests still running after %0d clock cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

endmodule
